/* build.f */
+incdir+include
src/mmu_pkg.sv
src/mmu_ctl_if.sv
src/map_ram.sv
src/mmu_ctl.sv
src/mmu_datapath.sv
src/mmu_top.sv
tests/mmu_tb.sv

/* Makefile */
# Verilator flow for the MMU control slice testbench

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module mmu_tb -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vmmu_tb | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/mmu_tb.sv */
// MMU testbench: clock and reset, access table, page table and inhibit map model, checks, watchdog
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_tb;
    import mmu_pkg::*;

    localparam int CLK_PERIOD = 4;

    // One access, stimulus first, then the expected results
    typedef struct packed {
        logic                   acc;
        logic                   ca0;
        logic                   write;
        logic                   dvacc;
        logic                   wchim;
        logic                   sex;          // Drives double
        logic                   emcl;
        logic                   wca;
        logic                   lshadow;
        logic [`MMU_LA_W-1:0]   la;
        logic [`MMU_LA_W-1:0]   idb_in;
        logic                   burst;        // Next row goes out on the very next cycle
        logic                   exp_pa;
        logic                   exp_idb;
        logic                   chk_cd;       // Inhibit bit known, or ecd forces it
        logic [`MMU_PPN_W-1:0]  exp_ppn;
        logic [`MMU_PROT_W-1:0] exp_prot;
        logic                   exp_cd;
        logic [`MMU_LA_W-1:0]   exp_idb_out;
    } row_t;

    logic                   clk;
    logic                   rst_n;
    logic                   acc;
    logic [`MMU_LA_W-1:0]   la;
    logic                   ca0;
    logic                   write;
    logic                   dvacc;
    logic                   rt;
    logic                   wchim;
    logic                   double;
    logic                   emcl;
    logic                   cc2;
    logic                   wca;
    logic                   lshadow;
    logic [`MMU_LA_W-1:0]   idb_in;
    logic [`MMU_PPN_W-1:0]  ppn;
    logic [`MMU_PROT_W-1:0] prot;
    logic                   cache_dis;
    logic [`MMU_LA_W-1:0]   idb_out;
    logic                   pa_valid;
    logic                   idb_valid;

    row_t                   rows [$];
    int                     slots [$];               // Row index per cycle, -1 is a gap
    pte_t                   model_pt [`MMU_PT_DEPTH];
    logic                   model_chim [int];        // Only pages written so far
    logic [`MMU_PPN_W-1:0]  model_last_ppn;          // PPN register as the map write sees it
    logic                   table_ready;
    int                     n_errors;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mmu_top dut_i (
        .clk(clk), .rst_n(rst_n), .acc(acc), .la(la),
        .ca0(ca0), .write(write), .dvacc(dvacc), .rt(rt),
        .wchim(wchim), .double(double), .emcl(emcl), .cc2(cc2),
        .wca(wca), .lshadow(lshadow), .idb_in(idb_in),
        .ppn(ppn), .prot(prot), .cache_dis(cache_dis), .idb_out(idb_out),
        .pa_valid(pa_valid), .idb_valid(idb_valid)
    );

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Wrong value on %s", name);
        end
    endtask

    function automatic logic [15:0] rand16();
        logic [31:0] r;
        r = $urandom();
        return r[15:0];
    endfunction

    // Random offset inside the page
    function automatic logic [`MMU_LA_W-1:0] page_addr(input logic [`MMU_PAGE_W-1:0] page);
        logic [31:0] r;
        r = $urandom();
        return {page, r[`MMU_LA_W-`MMU_PAGE_W-1:0]};
    endfunction

    function automatic row_t blank_row();
        row_t r;
        r = '0;
        r.acc = 1'b1;
        return r;
    endfunction

    task automatic add_idle();
        row_t r;
        r = '0;
        r.burst = 1'b1;              // Gap rows already are the spacing
        rows.push_back(r);
    endtask

    task automatic add_shadow_write(input logic [`MMU_PAGE_W-1:0] page, input logic sex,
                                    input logic upper, input logic [15:0] word,
                                    input logic burst);
        row_t r;
        r = blank_row();
        r.lshadow = 1'b1;
        r.write   = 1'b1;
        r.emcl    = 1'b1;            // Table kept off the IDB during the write
        r.sex     = sex;
        r.ca0     = upper;
        r.la      = page_addr(page);
        r.idb_in  = word;
        r.burst   = burst;
        if (!sex) begin                                    // REX, protect bits cleared
            model_pt[page].prot = '0;
            model_pt[page].ppn  = word[`MMU_PPN_W-1:0];
        end else if (upper) begin
            model_pt[page].prot = word[`MMU_LA_W-1 -: `MMU_PROT_W];
        end else begin
            model_pt[page].ppn  = word[`MMU_PPN_W-1:0];
        end
        rows.push_back(r);
    endtask

    task automatic add_shadow_read(input logic [`MMU_PAGE_W-1:0] page, input logic sex,
                                   input logic upper, input logic wca_on,
                                   input logic burst);
        row_t r;
        r = blank_row();
        r.lshadow = 1'b1;
        r.sex     = sex;
        r.ca0     = upper;
        r.wca     = wca_on;
        r.la      = page_addr(page);
        r.burst   = burst;
        r.exp_idb = 1'b1;
        r.chk_cd  = 1'b1;            // No PA out, only ecd can raise it
        r.exp_cd  = wca_on;
        if (upper) begin
            r.exp_idb_out = {model_pt[page].prot, {(`MMU_LA_W - `MMU_PROT_W){1'b0}}};
        end else begin
            r.exp_idb_out = {{(`MMU_LA_W - `MMU_PPN_W){1'b0}}, model_pt[page].ppn};
        end
        rows.push_back(r);
    endtask

    task automatic add_translate(input logic [`MMU_PAGE_W-1:0] page, input logic phys,
                                 input logic burst);
        row_t r;
        r = blank_row();
        r.la     = page_addr(page);
        r.dvacc  = phys;
        r.burst  = burst;
        r.exp_pa = 1'b1;
        if (phys) begin                                    // Logical page, no protection
            r.exp_ppn = '0;
            r.exp_ppn[`MMU_PAGE_W-1:0] = page;
            r.exp_prot = '0;
        end else begin
            r.exp_ppn  = model_pt[page].ppn;
            r.exp_prot = model_pt[page].prot;
        end
        model_last_ppn = r.exp_ppn;
        if (model_chim.exists(int'(r.exp_ppn))) begin
            r.chk_cd = 1'b1;
            r.exp_cd = model_chim[int'(r.exp_ppn)];
        end
        rows.push_back(r);
    endtask

    // Map entry at the last PPN put out takes idb_in bit 0
    task automatic add_chim_write(input logic inhibit, input logic burst);
        row_t r;
        logic [15:0] w;
        w = rand16();
        w[0] = inhibit;
        r = blank_row();
        r.wchim  = 1'b1;
        r.la     = rand16();
        r.idb_in = w;
        r.burst  = burst;
        model_chim[int'(model_last_ppn)] = inhibit;
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [`MMU_PAGE_W-1:0] pg;
        add_idle();                                        // Nothing valid out of reset
        add_idle();
        add_idle();
        add_shadow_write(5, 0, 0, rand16(), 1);            // REX write, read both words
        add_shadow_read(5, 0, 0, 0, 1);
        add_shadow_read(5, 0, 1, 0, 0);
        add_translate(5, 0, 0);
        add_shadow_write(20, 1, 1, rand16(), 1);           // SEX upper then lower
        add_shadow_write(20, 1, 0, rand16(), 1);
        add_shadow_read(20, 1, 1, 0, 1);
        add_shadow_read(20, 1, 0, 0, 0);
        add_translate(20, 0, 0);
        add_shadow_write(41, 1, 0, rand16(), 1);           // SEX lower then upper
        add_shadow_write(41, 1, 1, rand16(), 0);
        add_translate(41, 0, 0);
        add_translate(20, 1, 0);                           // Pass-through ignores the table
        add_translate(63, 1, 0);
        add_translate(20, 0, 0);                           // Inhibit one page, clear another
        add_chim_write(1, 0);
        add_translate(20, 0, 0);
        add_translate(5, 0, 0);
        add_chim_write(0, 0);
        add_translate(5, 0, 0);
        add_translate(20, 0, 0);
        add_shadow_read(5, 0, 0, 1, 0);                    // wca forces cache off
        for (pg = 6'd8; pg < 6'd12; pg++) begin
            add_shadow_write(pg, 0, 0, rand16(), 1);
        end
        for (pg = 6'd8; pg < 6'd12; pg++) begin            // Strobes on every cycle
            add_translate(pg, 0, 1);
        end
        add_shadow_read(9, 0, 0, 0, 1);
        add_translate(20, 0, 1);
        add_translate(33, 1, 1);
        add_shadow_read(11, 0, 0, 0, 1);
        add_translate(5, 0, 0);
    endtask

    task automatic apply_row(input row_t r);
        acc     = r.acc;
        la      = r.la;
        ca0     = r.ca0;
        write   = r.write;
        dvacc   = r.dvacc;
        wchim   = r.wchim;
        double  = r.sex;
        emcl    = r.emcl;
        wca     = r.wca;
        lshadow = r.lshadow;
        idb_in  = r.idb_in;
    endtask

    // Results of the row strobed two cycles back, valids checked on every cycle
    task automatic check_results(input int idx);
        row_t r;
        r = '0;
        if (idx >= 0) begin
            r = rows[idx];
        end
        compare("pa_valid", 32'(pa_valid), 32'(r.exp_pa));
        compare("idb_valid", 32'(idb_valid), 32'(r.exp_idb));
        if (r.exp_pa) begin
            compare("ppn", 32'(ppn), 32'(r.exp_ppn));
            compare("prot", 32'(prot), 32'(r.exp_prot));
        end
        if (r.chk_cd) begin
            compare("cache_dis", 32'(cache_dis), 32'(r.exp_cd));
        end
        if (r.exp_idb) begin
            compare("idb_out", 32'(idb_out), 32'(r.exp_idb_out));
        end
    endtask

    initial begin
        row_t gap;
        gap = '0;
        void'($urandom(32'h5b87_1b73));
        n_errors    = 0;
        table_ready = 1'b0;
        clk         = 1'b0;
        rst_n       = 1'b0;
        rt          = 1'b0;
        cc2         = 1'b0;
        apply_row(gap);
        build_table();
        foreach (rows[i]) begin
            slots.push_back(i);
            if (!rows[i].burst) begin
                slots.push_back(-1);                       // Result out before the next row
            end
        end
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        compare("pa_valid", 32'(pa_valid), 32'd0);          // Reset state
        compare("idb_valid", 32'(idb_valid), 32'd0);
        compare("ppn", 32'(ppn), 32'd0);
        compare("prot", 32'(prot), 32'd0);
        compare("idb_out", 32'(idb_out), 32'd0);
        for (int c = 0; c < slots.size() + 2; c++) begin
            if (c >= 2) begin
                check_results(slots[c-2]);
            end
            if (c < slots.size() && slots[c] >= 0) begin
                apply_row(rows[slots[c]]);
            end else begin
                apply_row(gap);
            end
            @(negedge clk);
        end
        if (n_errors == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "%0d checks failed", n_errors);
        end
    end

    // Four cycles per row covers the gaps, margin covers reset
    initial begin
        wait (table_ready);
        #((rows.size() * 4 + 40) * CLK_PERIOD);
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired before all table rows were checked");
    end

endmodule

/* src/mmu_top.sv */
// MMU control slice top: control decode, enable bundle and datapath
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   acc,
    input  logic [`MMU_LA_W-1:0]   la,
    input  logic                   ca0,
    input  logic                   write,
    input  logic                   dvacc,
    input  logic                   rt,
    input  logic                   wchim,
    input  logic                   double,
    input  logic                   emcl,
    input  logic                   cc2,
    input  logic                   wca,
    input  logic                   lshadow,
    input  logic [`MMU_LA_W-1:0]   idb_in,
    output logic [`MMU_PPN_W-1:0]  ppn,
    output logic [`MMU_PROT_W-1:0] prot,
    output logic                   cache_dis,
    output logic [`MMU_LA_W-1:0]   idb_out,
    output logic                   pa_valid,
    output logic                   idb_valid
);

    mmu_ctl_if u_en_if (.clk(clk));      // Eight low-true enables

    mmu_ctl u_ctl (
        .ca0     (ca0),
        .write   (write),
        .dvacc   (dvacc),
        .rt      (rt),
        .wchim   (wchim),
        .double  (double),
        .emcl    (emcl),
        .cc2     (cc2),
        .wca     (wca),
        .lshadow (lshadow),
        .acc     (acc),
        .ctl     (u_en_if.ctl)
    );

    mmu_datapath u_dp (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc       (acc),
        .la        (la),
        .ca0       (ca0),
        .double    (double),
        .write     (write),
        .lshadow   (lshadow),
        .idb_in    (idb_in),
        .en        (u_en_if.dp),
        .ppn       (ppn),
        .prot      (prot),
        .cache_dis (cache_dis),
        .idb_out   (idb_out),
        .pa_valid  (pa_valid),
        .idb_valid (idb_valid)
    );

endmodule

/* src/mmu_datapath.sv */
// MMU datapath: page table, cache inhibit map, PPN steering, IDB shadow read and write
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_datapath (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   acc,
    input  logic [`MMU_LA_W-1:0]   la,
    input  logic                   ca0,
    input  logic                   double,
    input  logic                   write,
    input  logic                   lshadow,
    input  logic [`MMU_LA_W-1:0]   idb_in,
    mmu_ctl_if.dp                  en,
    output logic [`MMU_PPN_W-1:0]  ppn,
    output logic [`MMU_PROT_W-1:0] prot,
    output logic                   cache_dis,
    output logic [`MMU_LA_W-1:0]   idb_out,
    output logic                   pa_valid,
    output logic                   idb_valid
);
    import mmu_pkg::*;

    logic [`MMU_PAGE_W-1:0] lpage;            // Page table index
    logic                   xl_req;           // Translation or pass-through
    logic                   rd_req;
    logic                   wr_req;
    logic                   chim_wr;
    pte_t                   pt_wdata;
    pte_t                   pt_rdata;
    pte_t                   wr_hold;          // Last entry image built by shadow writes
    logic [`MMU_PPN_W-1:0]  steer_ppn;
    logic [`MMU_PPN_W-1:0]  chim_addr;
    logic                   inh_bit;

    // Stage 1, table read in flight
    logic                   xl_s1;
    logic                   rd_s1;
    logic                   ecd_s1;
    logic                   lapa_s1;
    logic                   rd_upper_s1;
    logic [`MMU_PAGE_W-1:0] lpage_s1;
    logic                   ecd_s2;

    assign lpage = la[`MMU_LA_W-1 -: `MMU_PAGE_W];

    // Request decode from the enables, sampled only with acc
    assign xl_req  = acc & ~lshadow & (~en.epmap_n | ~en.lapa_n);
    assign rd_req  = acc & lshadow & ~write & (~en.epti_n | ~en.ept_n);
    assign wr_req  = acc & lshadow & write & (~en.eipu_n | ~en.eipl_n | ~en.eipur_n);
    assign chim_wr = acc & ~lshadow & ~en.eipu_n & ~en.eipl_n;   // Only wchim opens both off-shadow

    // Entry image for a shadow write
    always_comb begin
        pt_wdata = wr_hold;
        if (!en.eipur_n) begin                   // REX, one word, protect masked
            pt_wdata.prot = '0;
            pt_wdata.ppn  = idb_in[`MMU_PPN_W-1:0];
        end else if (double && ca0) begin        // SEX upper word
            pt_wdata.prot = idb_in[`MMU_LA_W-1 -: `MMU_PROT_W];
        end else begin                           // SEX lower word
            pt_wdata.ppn  = idb_in[`MMU_PPN_W-1:0];
        end
    end

    // Keeps the other half so the two SEX word writes combine in either order
    always_ff @(posedge clk) begin
        if (wr_req) begin
            wr_hold <= pt_wdata;
        end
    end

    map_ram #(
        .DEPTH   (`MMU_PT_DEPTH),
        .entry_t (pte_t)
    ) u_pt (
        .clk   (clk),
        .we    (wr_req),
        .addr  (lpage),
        .wdata (pt_wdata),
        .rdata (pt_rdata)
    );

    // Stage 1 control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            xl_s1  <= 1'b0;
            rd_s1  <= 1'b0;
            ecd_s1 <= 1'b0;
        end else begin
            xl_s1  <= xl_req;
            rd_s1  <= rd_req;
            ecd_s1 <= acc & ~en.ecd_n;
        end
    end

    // Stage 1 payload
    always_ff @(posedge clk) begin
        if (acc) begin
            lapa_s1     <= ~en.lapa_n;
            rd_upper_s1 <= ca0;                  // ca0 picks the upper word on reads
            lpage_s1    <= lpage;
        end
    end

    // Logical page zero-extended when translation is off
    assign steer_ppn = lapa_s1 ? {{(`MMU_PPN_W - `MMU_PAGE_W){1'b0}}, lpage_s1} : pt_rdata.ppn;

    // Inhibit write targets the last PPN put out, else look up the steered page
    assign chim_addr = chim_wr ? ppn : steer_ppn;

    map_ram #(
        .DEPTH   (`MMU_CHIM_DEPTH),
        .entry_t (logic)
    ) u_chim (
        .clk   (clk),
        .we    (chim_wr),
        .addr  (chim_addr),
        .wdata (idb_in[0]),
        .rdata (inh_bit)
    );

    // Stage 2, outputs
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pa_valid  <= 1'b0;
            idb_valid <= 1'b0;
            ecd_s2    <= 1'b0;
            ppn       <= '0;
            prot      <= '0;
            idb_out   <= '0;
        end else begin
            pa_valid  <= xl_s1;
            idb_valid <= rd_s1;
            ecd_s2    <= ecd_s1;
            if (xl_s1) begin
                ppn  <= steer_ppn;
                prot <= lapa_s1 ? '0 : pt_rdata.prot;   // Physical pages unprotected
            end
            if (rd_s1) begin
                idb_out <= rd_upper_s1 ? pte_hi_word(pt_rdata) : pte_lo_word(pt_rdata);
            end
        end
    end

    assign cache_dis = (inh_bit & pa_valid) | ecd_s2;   // Inhibit bit only counts on a PA

endmodule

/* src/mmu_ctl.sv */
// MMU control decode: PAL sum-of-products enables, access kind and enable checks
`timescale 1ns/1ps

module mmu_ctl (
    input  logic   ca0,
    input  logic   write,
    input  logic   dvacc,
    input  logic   rt,
    input  logic   wchim,
    input  logic   double,
    input  logic   emcl,
    input  logic   cc2,
    input  logic   wca,
    input  logic   lshadow,
    input  logic   acc,
    mmu_ctl_if.ctl ctl
);
    import mmu_pkg::*;

    // Low-true forms as the PAL sees them
    logic wchim_n;
    logic double_n;
    logic emcl_n;
    logic cc2_n;
    logic dvacc_n;
    logic ca0_n;
    logic write_n;
    logic lshadow_n;
    acc_kind_t kind;

    assign wchim_n   = ~wchim;
    assign double_n  = ~double;
    assign emcl_n    = ~emcl;
    assign cc2_n     = ~cc2;
    assign dvacc_n   = ~dvacc;
    assign ca0_n     = ~ca0;
    assign write_n   = ~write;
    assign lshadow_n = ~lshadow;

    // rt and wca enter the equations high-true, so they need no inversion
    assign ctl.ecd_n   = ~((wca & lshadow) |                // Shadow data kept out of cache
                           (rt & lshadow_n & cc2_n));       // Cache write path
    assign ctl.lapa_n  = ~(dvacc & lshadow_n & wchim_n);    // Virtual accesses off

    assign ctl.eipur_n = ~(double_n & lshadow & write);     // REX write drops protect bits

    assign ctl.eipu_n  = ~(wchim |                          // Page to inhibit from IDB
                           (double & lshadow & ca0) |
                           (double & lshadow & write));     // SEX full entry write
    assign ctl.eipl_n  = ~(wchim |
                           (double & lshadow & ca0) |
                           (double & lshadow & write));

    // Held off while emcl owns the IDB
    assign ctl.epti_n  = ~((lshadow & emcl_n & write) |
                           (lshadow & emcl_n & double_n) |
                           (lshadow & emcl_n & ca0_n));

    assign ctl.epmap_n = ~((wchim_n & dvacc_n & write_n) |
                           (wchim_n & dvacc_n & lshadow_n) |
                           (wchim_n & dvacc_n & double_n) |
                           (wchim_n & dvacc_n & ca0) |
                           (wchim_n & lshadow & write_n) |
                           (wchim_n & lshadow & double_n) |
                           (wchim_n & lshadow & ca0));

    assign ctl.ept_n   = ~((write_n & emcl_n) |
                           (lshadow_n & emcl_n) |
                           (double_n & emcl_n) |
                           (ca0_n & emcl_n));

    // Access kind, inhibit write first, then shadow, then pass-through
    always_comb begin
        if (wchim) begin
            kind = ACC_CHIM_WR;
        end else if (lshadow) begin
            kind = write ? ACC_SHADOW_WR : ACC_SHADOW_RD;
        end else if (dvacc) begin
            kind = ACC_PHYS;
        end else begin
            kind = ACC_XLATE;
        end
    end

    // Only one source may drive the PPN bus
    a_ppn_src_excl: assert property (@(posedge ctl.clk)
        acc |-> (ctl.lapa_n || ctl.epmap_n));

    // Microcode raises emcl on shadow writes, so the table never drives the IDB being written
    a_shw_no_ept: assert property (@(posedge ctl.clk)
        acc && (kind == ACC_SHADOW_WR) |-> (ctl.eipu_n || ctl.ept_n));

    a_chim_no_lapa: assert property (@(posedge ctl.clk)
        acc && (kind == ACC_CHIM_WR) |-> ctl.lapa_n);   // Inhibit map takes the PPN bus

endmodule

/* src/map_ram.sv */
// Single-port synchronous table: type-parameter payload, write-first, registered read
`timescale 1ns/1ps

module map_ram #(
    parameter int  DEPTH   = 64,
    parameter type entry_t = logic
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  entry_t                   wdata,
    output entry_t                   rdata
);

    entry_t mem [DEPTH];          // Table storage, contents undefined at power-up

    // One access per cycle, read data one clock later
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
            rdata     <= wdata;   // Write-first, new value returned
        end else begin
            rdata     <= mem[addr];
        end
    end

endmodule

/* src/mmu_ctl_if.sv */
// MMU enable bundle: eight active-low enables from the control decode to the datapath
`timescale 1ns/1ps

interface mmu_ctl_if (
    input logic clk               // Only used by checks on the control side
);
    logic ecd_n;                  // Disable cache
    logic lapa_n;                 // Logical page onto PPN bus
    logic eipur_n;                // Mask protect bits on REX shadow write
    logic eipu_n;                 // IDB to upper entry word
    logic eipl_n;                 // IDB to lower entry word
    logic epti_n;                 // Entry word onto IDB
    logic epmap_n;                // Page table PPN onto PPN bus
    logic ept_n;                  // Page table output enable

    modport ctl (
        input  clk,
        output ecd_n, lapa_n, eipur_n, eipu_n, eipl_n, epti_n, epmap_n, ept_n
    );

    modport dp (
        input  ecd_n, lapa_n, eipur_n, eipu_n, eipl_n, epti_n, epmap_n, ept_n
    );

endinterface

/* src/mmu_pkg.sv */
// MMU package: page table entry type, access kind enum, entry word layout functions
`include "mmu_params.svh"

package mmu_pkg;

    // One page table entry, protect bits above the page number
    typedef struct packed {
        logic [`MMU_PROT_W-1:0] prot;
        logic [`MMU_PPN_W-1:0]  ppn;
    } pte_t;

    // Decoded kind of one access strobe
    typedef enum logic [2:0] {
        ACC_XLATE     = 3'd0, // Page table supplies the PPN
        ACC_PHYS      = 3'd1, // Logical page passed through
        ACC_SHADOW_RD = 3'd2,
        ACC_SHADOW_WR = 3'd3,
        ACC_CHIM_WR   = 3'd4  // Cache inhibit map write
    } acc_kind_t;

    // Upper IDB word: protect bits on top, rest reads zero
    function automatic logic [`MMU_LA_W-1:0] pte_hi_word(pte_t e);
        return {e.prot, {(`MMU_LA_W - `MMU_PROT_W){1'b0}}};
    endfunction

    // Lower IDB word: page number in the low bits, top bits zero
    function automatic logic [`MMU_LA_W-1:0] pte_lo_word(pte_t e);
        return {{(`MMU_LA_W - `MMU_PPN_W){1'b0}}, e.ppn};
    endfunction

endpackage

/* include/mmu_params.svh */
// MMU width and table size macros: logical address, page index, PPN, protect bits, table depths
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// Logical address and IDB word width
`define MMU_LA_W      16

// Page index taken from the top of the logical address
`define MMU_PAGE_W    6

// Physical page number and protect field widths
`define MMU_PPN_W     14
`define MMU_PROT_W    7

// Page table has one entry per logical page
`define MMU_PT_DEPTH   (1 << `MMU_PAGE_W)

// Cache inhibit map has one bit per physical page
`define MMU_CHIM_DEPTH (1 << `MMU_PPN_W)

`endif
